/* rtl/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

    // rv32i major opcodes
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [2:0] FUNCT3_ADD = 3'b000;
    localparam logic [2:0] FUNCT3_AND = 3'b111;
    localparam logic [2:0] FUNCT3_OR  = 3'b110;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_OR  = 2'b11
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00, // value read in decode
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_t;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0
    localparam word_t PC_STEP   = 32'd4;

endpackage

`default_nettype wire

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import rv_core_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_stall,
    input  word_t i_im_data,
    output word_t o_im_addr,
    output word_t o_instr,
    output word_t o_pc
);

    word_t pc;

    assign o_im_addr = pc; // rom answers in the same cycle

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc      <= RESET_PC;
            o_instr <= NOP_INSTR;
            o_pc    <= RESET_PC;
        end else if (!i_stall) begin
            pc      <= pc + PC_STEP;
            o_instr <= i_im_data;
            o_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage import rv_core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_stall,
    input  word_t     i_instr,
    output reg_addr_t o_rs1_addr,
    output reg_addr_t o_rs2_addr,
    input  word_t     i_rs1_data,
    input  word_t     i_rs2_data,
    output reg_addr_t o_ex_rs1_addr,
    output reg_addr_t o_ex_rs2_addr,
    output reg_addr_t o_ex_rd,
    output word_t     o_ex_rs1_data,
    output word_t     o_ex_rs2_data,
    output word_t     o_ex_imm,
    output alu_op_t   o_ex_alu_op,
    output logic      o_ex_use_imm,
    output logic      o_ex_mem_read,
    output logic      o_ex_mem_write,
    output logic      o_ex_reg_write,
    output logic      o_ex_mem_to_reg
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_t    alu_op;
    logic       legal;
    logic       is_reg, is_imm, is_load, is_store;
    word_t      imm;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b1;
        case (opcode)
            OP_REG: begin
                case (funct3)
                    FUNCT3_ADD: alu_op = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
                    FUNCT3_AND: alu_op = ALU_AND;
                    FUNCT3_OR:  alu_op = ALU_OR;
                    default:    legal  = 1'b0;
                endcase
            end
            OP_IMM: begin
                case (funct3)
                    FUNCT3_ADD: alu_op = ALU_ADD;
                    FUNCT3_AND: alu_op = ALU_AND;
                    default:    legal  = 1'b0;
                endcase
            end
            OP_LOAD, OP_STORE: alu_op = ALU_ADD; // address = rs1 + imm
            default:           legal  = 1'b0;    // anything else runs as a nop
        endcase
    end

    assign is_reg   = legal && (opcode == OP_REG);
    assign is_imm   = legal && (opcode == OP_IMM);
    assign is_load  = legal && (opcode == OP_LOAD);
    assign is_store = legal && (opcode == OP_STORE);

    // only real sources reach the hazard unit
    assign o_rs1_addr = legal ? i_instr[19:15] : '0;
    assign o_rs2_addr = (is_reg || is_store) ? i_instr[24:20] : '0;

    assign imm = is_store ? {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]}
                          : {{20{i_instr[31]}}, i_instr[31:20]};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_rs1_addr   <= '0;
            o_ex_rs2_addr   <= '0;
            o_ex_rd         <= '0;
            o_ex_alu_op     <= ALU_ADD;
            o_ex_use_imm    <= 1'b0;
            o_ex_mem_read   <= 1'b0;
            o_ex_mem_write  <= 1'b0;
            o_ex_reg_write  <= 1'b0;
            o_ex_mem_to_reg <= 1'b0;
        end else begin
            o_ex_rs1_addr   <= o_rs1_addr;
            o_ex_rs2_addr   <= o_rs2_addr;
            o_ex_rd         <= i_instr[11:7];
            o_ex_alu_op     <= alu_op;
            o_ex_use_imm    <= !is_reg;
            o_ex_mem_read   <= is_load && !i_stall; // bubble on stall
            o_ex_mem_write  <= is_store && !i_stall;
            o_ex_reg_write  <= (is_reg || is_imm || is_load) && !i_stall;
            o_ex_mem_to_reg <= is_load && !i_stall;
        end
    end

    always_ff @(posedge i_clk) begin
        o_ex_rs1_data <= i_rs1_data;
        o_ex_rs2_data <= i_rs2_data;
        o_ex_imm      <= imm;
    end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  reg_addr_t i_rs1_addr,
    input  reg_addr_t i_rs2_addr,
    input  reg_addr_t i_wr_addr,
    input  logic      i_wr_en,
    input  word_t     i_wr_data,
    output word_t     o_rs1_data,
    output word_t     o_rs2_data
);

    word_t regs [1:NUM_REGS-1]; // x0 has no storage

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // write-through so decode sees the writeback of this cycle
    assign o_rs1_data = (i_rs1_addr == '0)                         ? '0 :
                        (i_wr_en && (i_wr_addr == i_rs1_addr))     ? i_wr_data :
                                                                     regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0)                         ? '0 :
                        (i_wr_en && (i_wr_addr == i_rs2_addr))     ? i_wr_data :
                                                                     regs[i_rs2_addr];

endmodule

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import rv_core_pkg::*; (
    input  reg_addr_t i_id_rs1,
    input  reg_addr_t i_id_rs2,
    input  reg_addr_t i_ex_rs1,
    input  reg_addr_t i_ex_rs2,
    input  reg_addr_t i_ex_rd,
    input  reg_addr_t i_mem_rd,
    input  reg_addr_t i_wb_rd,
    input  logic      i_ex_mem_read,
    input  logic      i_mem_reg_write,
    input  logic      i_wb_reg_write,
    output logic      o_stall,
    output fwd_sel_t  o_fwd_a,
    output fwd_sel_t  o_fwd_b
);

    function automatic fwd_sel_t fwd_pick(
        input reg_addr_t rs,
        input reg_addr_t mem_rd,
        input logic      mem_we,
        input reg_addr_t wb_rd,
        input logic      wb_we
    );
        if (rs == '0)
            return FWD_REG;
        else if (mem_we && (mem_rd == rs))
            return FWD_MEM; // newest value wins
        else if (wb_we && (wb_rd == rs))
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    // load in execute feeding the instruction in decode
    assign o_stall = i_ex_mem_read && (i_ex_rd != '0) &&
                     ((i_ex_rd == i_id_rs1) || (i_ex_rd == i_id_rs2));

    assign o_fwd_a = fwd_pick(i_ex_rs1, i_mem_rd, i_mem_reg_write, i_wb_rd, i_wb_reg_write);
    assign o_fwd_b = fwd_pick(i_ex_rs2, i_mem_rd, i_mem_reg_write, i_wb_rd, i_wb_reg_write);

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage import rv_core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  reg_addr_t i_ex_rs1_addr,
    input  reg_addr_t i_ex_rs2_addr,
    input  reg_addr_t i_ex_rd,
    input  word_t     i_ex_rs1_data,
    input  word_t     i_ex_rs2_data,
    input  word_t     i_ex_imm,
    input  alu_op_t   i_ex_alu_op,
    input  logic      i_ex_use_imm,
    input  logic      i_ex_mem_read,
    input  logic      i_ex_mem_write,
    input  logic      i_ex_reg_write,
    input  logic      i_ex_mem_to_reg,
    input  fwd_sel_t  i_fwd_a,
    input  fwd_sel_t  i_fwd_b,
    input  word_t     i_wb_data,
    output word_t     o_mem_alu_result,
    output word_t     o_mem_store_data,
    output reg_addr_t o_mem_rd,
    output logic      o_mem_mem_read,
    output logic      o_mem_mem_write,
    output logic      o_mem_reg_write,
    output logic      o_mem_mem_to_reg
);

    word_t op_a;
    word_t rs2_val;
    word_t op_b;
    word_t alu_result;

    function automatic word_t fwd_mux(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    wb_val,
        input word_t    mem_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(i_fwd_a, i_ex_rs1_data, i_wb_data, o_mem_alu_result);
    assign rs2_val = fwd_mux(i_fwd_b, i_ex_rs2_data, i_wb_data, o_mem_alu_result); // also sw data
    assign op_b    = i_ex_use_imm ? i_ex_imm : rs2_val;

    always_comb begin
        case (i_ex_alu_op)
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_rd         <= '0;
            o_mem_mem_read   <= 1'b0;
            o_mem_mem_write  <= 1'b0;
            o_mem_reg_write  <= 1'b0;
            o_mem_mem_to_reg <= 1'b0;
        end else begin
            o_mem_rd         <= i_ex_rd;
            o_mem_mem_read   <= i_ex_mem_read;
            o_mem_mem_write  <= i_ex_mem_write;
            o_mem_reg_write  <= i_ex_reg_write;
            o_mem_mem_to_reg <= i_ex_mem_to_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        o_mem_alu_result <= alu_result;
        o_mem_store_data <= rs2_val;
    end

endmodule

`default_nettype wire

/* rtl/mem_wb_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_wb_stage import rv_core_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  word_t     i_mem_alu_result,
    input  word_t     i_mem_store_data,
    input  reg_addr_t i_mem_rd,
    input  logic      i_mem_mem_read,
    input  logic      i_mem_mem_write,
    input  logic      i_mem_reg_write,
    input  logic      i_mem_mem_to_reg,
    input  word_t     i_dm_rdata,
    output word_t     o_dm_addr,
    output word_t     o_dm_wdata,
    output logic      o_dm_cs,
    output logic      o_dm_we,
    output reg_addr_t o_wb_rd,
    output logic      o_wb_reg_write,
    output word_t     o_wb_data
);

    logic  wb_mem_to_reg;
    word_t wb_load_data;
    word_t wb_alu_result;

    assign o_dm_addr  = i_mem_alu_result;
    assign o_dm_wdata = i_mem_store_data;
    assign o_dm_cs    = i_mem_mem_read || i_mem_mem_write;
    assign o_dm_we    = i_mem_mem_write; // whole word, no byte lanes

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_rd        <= '0;
            o_wb_reg_write <= 1'b0;
            wb_mem_to_reg  <= 1'b0;
        end else begin
            o_wb_rd        <= i_mem_rd;
            o_wb_reg_write <= i_mem_reg_write;
            wb_mem_to_reg  <= i_mem_mem_to_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        wb_load_data  <= i_dm_rdata;
        wb_alu_result <= i_mem_alu_result;
    end

    assign o_wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core import rv_core_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    output word_t o_im_addr,
    input  word_t i_im_data,
    output word_t o_dm_addr,
    output word_t o_dm_wdata,
    output logic  o_dm_cs,
    output logic  o_dm_we,
    input  word_t i_dm_rdata
);

    logic      stall;
    fwd_sel_t  fwd_a, fwd_b;

    word_t     id_instr;
    reg_addr_t id_rs1_addr, id_rs2_addr;
    word_t     id_rs1_data, id_rs2_data;

    reg_addr_t ex_rs1_addr, ex_rs2_addr, ex_rd;
    word_t     ex_rs1_data, ex_rs2_data, ex_imm;
    alu_op_t   ex_alu_op;
    logic      ex_use_imm, ex_mem_read, ex_mem_write, ex_reg_write, ex_mem_to_reg;

    word_t     mem_alu_result, mem_store_data;
    reg_addr_t mem_rd;
    logic      mem_mem_read, mem_mem_write, mem_reg_write, mem_mem_to_reg;

    reg_addr_t wb_rd;
    logic      wb_reg_write;
    word_t     wb_data;

    fetch_stage u_fetch (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_stall   (stall),
        .i_im_data (i_im_data),
        .o_im_addr (o_im_addr),
        .o_instr   (id_instr),
        .o_pc      ()          // no branch target path
    );

    decode_stage u_decode (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_stall         (stall),
        .i_instr         (id_instr),
        .o_rs1_addr      (id_rs1_addr),
        .o_rs2_addr      (id_rs2_addr),
        .i_rs1_data      (id_rs1_data),
        .i_rs2_data      (id_rs2_data),
        .o_ex_rs1_addr   (ex_rs1_addr),
        .o_ex_rs2_addr   (ex_rs2_addr),
        .o_ex_rd         (ex_rd),
        .o_ex_rs1_data   (ex_rs1_data),
        .o_ex_rs2_data   (ex_rs2_data),
        .o_ex_imm        (ex_imm),
        .o_ex_alu_op     (ex_alu_op),
        .o_ex_use_imm    (ex_use_imm),
        .o_ex_mem_read   (ex_mem_read),
        .o_ex_mem_write  (ex_mem_write),
        .o_ex_reg_write  (ex_reg_write),
        .o_ex_mem_to_reg (ex_mem_to_reg)
    );

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (id_rs1_addr),
        .i_rs2_addr (id_rs2_addr),
        .i_wr_addr  (wb_rd),
        .i_wr_en    (wb_reg_write),
        .i_wr_data  (wb_data),
        .o_rs1_data (id_rs1_data),
        .o_rs2_data (id_rs2_data)
    );

    hazard_unit u_hazard (
        .i_id_rs1        (id_rs1_addr),
        .i_id_rs2        (id_rs2_addr),
        .i_ex_rs1        (ex_rs1_addr),
        .i_ex_rs2        (ex_rs2_addr),
        .i_ex_rd         (ex_rd),
        .i_mem_rd        (mem_rd),
        .i_wb_rd         (wb_rd),
        .i_ex_mem_read   (ex_mem_read),
        .i_mem_reg_write (mem_reg_write),
        .i_wb_reg_write  (wb_reg_write),
        .o_stall         (stall),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b)
    );

    execute_stage u_execute (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_ex_rs1_addr    (ex_rs1_addr),
        .i_ex_rs2_addr    (ex_rs2_addr),
        .i_ex_rd          (ex_rd),
        .i_ex_rs1_data    (ex_rs1_data),
        .i_ex_rs2_data    (ex_rs2_data),
        .i_ex_imm         (ex_imm),
        .i_ex_alu_op      (ex_alu_op),
        .i_ex_use_imm     (ex_use_imm),
        .i_ex_mem_read    (ex_mem_read),
        .i_ex_mem_write   (ex_mem_write),
        .i_ex_reg_write   (ex_reg_write),
        .i_ex_mem_to_reg  (ex_mem_to_reg),
        .i_fwd_a          (fwd_a),
        .i_fwd_b          (fwd_b),
        .i_wb_data        (wb_data),
        .o_mem_alu_result (mem_alu_result),
        .o_mem_store_data (mem_store_data),
        .o_mem_rd         (mem_rd),
        .o_mem_mem_read   (mem_mem_read),
        .o_mem_mem_write  (mem_mem_write),
        .o_mem_reg_write  (mem_reg_write),
        .o_mem_mem_to_reg (mem_mem_to_reg)
    );

    mem_wb_stage u_mem_wb (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_mem_alu_result (mem_alu_result),
        .i_mem_store_data (mem_store_data),
        .i_mem_rd         (mem_rd),
        .i_mem_mem_read   (mem_mem_read),
        .i_mem_mem_write  (mem_mem_write),
        .i_mem_reg_write  (mem_reg_write),
        .i_mem_mem_to_reg (mem_mem_to_reg),
        .i_dm_rdata       (i_dm_rdata),
        .o_dm_addr        (o_dm_addr),
        .o_dm_wdata       (o_dm_wdata),
        .o_dm_cs          (o_dm_cs),
        .o_dm_we          (o_dm_we),
        .o_wb_rd          (wb_rd),
        .o_wb_reg_write   (wb_reg_write),
        .o_wb_data        (wb_data)
    );

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model import rv_core_pkg::*; (
    input  logic  i_clk,
    input  word_t i_im_addr,
    output word_t o_im_data,
    input  word_t i_dm_addr,
    input  logic  i_dm_cs,
    input  logic  i_dm_we,
    input  word_t i_dm_wdata,
    output word_t o_dm_rdata
);

    localparam int DEPTH = 256;

    word_t rom [0:DEPTH-1]; // program written by the testbench
    word_t ram [0:DEPTH-1];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            ram[i] = '0;
        end
    end

    // fetches past the rom see nops
    assign o_im_data = (i_im_addr[31:10] == '0) ? rom[i_im_addr[9:2]] : NOP_INSTR;

    assign o_dm_rdata = i_dm_cs ? ram[i_dm_addr[9:2]] : '0;

    always @(posedge i_clk) begin
        if (i_dm_cs && i_dm_we) begin
            ram[i_dm_addr[9:2]] <= i_dm_wdata;
        end
    end

endmodule

`default_nettype wire

/* tests/tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

    localparam int    NUM_RANDOM     = 40;
    localparam int    TIMEOUT_CYCLES = 300;
    localparam int    DRAIN_CYCLES   = 12;
    localparam word_t STORE_BASE     = 32'h0000_0100;

    logic  clk;
    logic  rst_n;
    word_t im_addr, im_data;
    word_t dm_addr, dm_wdata, dm_rdata;
    logic  dm_cs, dm_we;

    word_t       ref_regs [0:31];
    word_t       ref_mem  [0:255];
    word_t       exp_addr_q [$];
    word_t       exp_data_q [$];
    word_t       exp_fetch_q [$];
    logic [31:0] lcg_state;
    int          exp_total;
    int          store_count;
    int          fetch_errors, addr_errors, data_errors, other_errors;
    int          cycles;

    rv_core uut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .o_im_addr  (im_addr),
        .i_im_data  (im_data),
        .o_dm_addr  (dm_addr),
        .o_dm_wdata (dm_wdata),
        .o_dm_cs    (dm_cs),
        .o_dm_we    (dm_we),
        .i_dm_rdata (dm_rdata)
    );

    tb_mem_model u_mem (
        .i_clk      (clk),
        .i_im_addr  (im_addr),
        .o_im_data  (im_data),
        .i_dm_addr  (dm_addr),
        .i_dm_cs    (dm_cs),
        .i_dm_we    (dm_we),
        .i_dm_wdata (dm_wdata),
        .o_dm_rdata (dm_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8; // low bits cycle too fast
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() % n);
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input reg_addr_t rs1, input reg_addr_t rs2,
                                    input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    // mostly the last one or two destinations, so results get forwarded
    function automatic reg_addr_t pick_src(input reg_addr_t last_rd, input reg_addr_t prev_rd);
        int sel;
        sel = rand_below(4);
        if (sel < 2)
            return last_rd;
        else if (sel == 2)
            return prev_rd;
        else
            return reg_addr_t'(rand_below(8));
    endfunction

    // true when cons reads the nonzero destination of the load prod
    function automatic logic load_use(input word_t prod, input word_t cons);
        reg_addr_t rd;
        logic      uses_rs2;
        rd       = prod[11:7];
        uses_rs2 = (cons[6:0] == OP_REG) || (cons[6:0] == OP_STORE);
        return (prod[6:0] == OP_LOAD) && (rd != 5'd0) &&
               ((cons[19:15] == rd) || (uses_rs2 && (cons[24:20] == rd)));
    endfunction

    // runs one instruction on the model state and queues its store
    function automatic void ref_exec(input word_t instr);
        logic [6:0] opc;
        logic [2:0] f3;
        reg_addr_t  rd, rs1, rs2;
        word_t      a, b, imm_i, imm_s, ea, res;
        logic       wr;
        opc   = instr[6:0];
        f3    = instr[14:12];
        rd    = instr[11:7];
        rs1   = instr[19:15];
        rs2   = instr[24:20];
        a     = ref_regs[rs1];
        b     = ref_regs[rs2];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        res   = '0;
        wr    = 1'b1;
        case (opc)
            OP_REG: begin
                case (f3)
                    3'b000:  res = instr[30] ? a - b : a + b;
                    3'b111:  res = a & b;
                    3'b110:  res = a | b;
                    default: wr  = 1'b0;
                endcase
            end
            OP_IMM: begin
                case (f3)
                    3'b000:  res = a + imm_i;
                    3'b111:  res = a & imm_i;
                    default: wr  = 1'b0;
                endcase
            end
            OP_LOAD: begin
                ea  = a + imm_i;
                res = ref_mem[ea[9:2]];
            end
            OP_STORE: begin
                wr = 1'b0;
                ea = a + imm_s;
                exp_addr_q.push_back(ea);
                exp_data_q.push_back(b);
                ref_mem[ea[9:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0)
            ref_regs[rd] = res;
    endfunction

    task automatic build_program();
        word_t       prog [$];
        word_t       instr;
        reg_addr_t   rd, rs1, rs2, last_rd, prev_rd;
        logic [11:0] imm, mem_off;
        int          kind;
        last_rd = 5'd7;
        prev_rd = 5'd6;
        for (int r = 1; r < 8; r++) begin
            prog.push_back(enc_i(OP_IMM, FUNCT3_ADD, reg_addr_t'(r), 5'd0, 12'(lcg_next())));
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            kind    = rand_below(8);
            rd      = reg_addr_t'(rand_below(8)); // x0 now and then
            rs1     = pick_src(last_rd, prev_rd);
            rs2     = pick_src(last_rd, prev_rd);
            imm     = 12'(lcg_next());
            mem_off = 12'(4 * rand_below(16));
            case (kind)
                0:       instr = enc_r(7'b0, FUNCT3_ADD, rd, rs1, rs2);
                1:       instr = enc_r(FUNCT7_SUB, FUNCT3_ADD, rd, rs1, rs2);
                2:       instr = enc_r(7'b0, FUNCT3_AND, rd, rs1, rs2);
                3:       instr = enc_r(7'b0, FUNCT3_OR, rd, rs1, rs2);
                4:       instr = enc_i(OP_IMM, FUNCT3_ADD, rd, rs1, imm);
                5:       instr = enc_i(OP_IMM, FUNCT3_AND, rd, rs1, imm);
                6:       instr = enc_i(OP_LOAD, 3'b010, rd, 5'd0, mem_off);
                default: instr = enc_s(5'd0, rs2, mem_off);
            endcase
            prog.push_back(instr);
            if (kind != 7) begin
                prev_rd = last_rd;
                last_rd = rd;
            end
        end
        for (int r = 0; r < 8; r++) begin
            prog.push_back(enc_s(5'd0, reg_addr_t'(r), 12'(STORE_BASE + 4 * r)));
        end
        for (int i = 0; i < 256; i++) begin
            u_mem.rom[i] = (i < prog.size()) ? prog[i] : NOP_INSTR;
        end
        for (int i = 0; i < prog.size(); i++) begin
            exp_fetch_q.push_back(RESET_PC + PC_STEP * word_t'(i));
            if (i >= 2 && load_use(prog[i-2], prog[i-1]))
                exp_fetch_q.push_back(RESET_PC + PC_STEP * word_t'(i)); // pc holds one cycle
        end
        foreach (prog[i]) begin
            ref_exec(prog[i]);
        end
    endtask

    task automatic check_fetch(input word_t got, input word_t exp);
        if (got !== exp) begin
            fetch_errors++;
            $display("ERR %0t: fetch address %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_addr(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            addr_errors++;
            $display("ERR %0t: store %0d address %h, expected %h", $time, idx, got, exp);
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            data_errors++;
            $display("ERR %0t: store %0d data %h, expected %h", $time, idx, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (exp_fetch_q.size() != 0)
                check_fetch(im_addr, exp_fetch_q.pop_front());
            if (dm_we) begin
                if (dm_cs !== 1'b1) begin
                    other_errors++;
                    $display("write enable without chip select at %0t", $time);
                end
                if (exp_addr_q.size() == 0) begin
                    other_errors++;
                    $display("store to %h at %0t that the program does not make",
                             dm_addr, $time);
                end else begin
                    check_addr(dm_addr, exp_addr_q.pop_front(), store_count);
                    check_data(dm_wdata, exp_data_q.pop_front(), store_count);
                end
                store_count++;
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        lcg_state    = 32'd60531;
        store_count  = 0;
        fetch_errors = 0;
        addr_errors  = 0;
        data_errors  = 0;
        other_errors = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = '0;
        end
        build_program();
        exp_total = exp_addr_q.size();

        repeat (2) @(posedge clk);
        if (dm_cs !== 1'b0 || dm_we !== 1'b0) begin
            other_errors++;
            $display("data bus active during reset at %0t", $time);
        end
        rst_n <= 1'b1;

        cycles = 0;
        while (store_count < exp_total && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (store_count < exp_total) begin
            other_errors++;
            $display("timed out after %0d cycles with %0d of %0d stores seen",
                     cycles, store_count, exp_total);
        end

        // a few more cycles to catch extra stores
        cycles = 0;
        while (cycles < DRAIN_CYCLES) begin
            @(negedge clk);
            cycles++;
        end

        $display("errors: fetch %0d, addr %0d, data %0d, other %0d; stores %0d of %0d",
                 fetch_errors, addr_errors, data_errors, other_errors,
                 store_count, exp_total);
        if (fetch_errors + addr_errors + data_errors + other_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/rv_core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv_core.sv
tests/tb_mem_model.sv
tests/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_rv_core
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulator output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
